// File: build.f
logic/vec_front_pkg.sv
logic/vec_front_ifs.sv
logic/instr_classifier.sv
logic/vcfg_regs.sv
logic/renaming_unit.sv
logic/vrf_beat_seq.sv
logic/vec_front_top.sv
verif/tb_vec_front.sv

// File: logic/instr_classifier.sv
`timescale 1ns/1ns
`default_nettype none

module instr_classifier
  (
   input  wire logic        clk,
   input  wire logic        rst_n_i,
   input  wire logic        instr_vld_i,
   input  wire logic [31:0] instr_i,
   dec_if.src               dec
   );

   logic [31:0]                 instr_q;
   logic                        vld_q;
   logic [2:0]                  vlmul;
   vec_front_pkg::instr_class_e cls;

   // word is held until the next strobe
   always_ff @(posedge clk)
   begin
      if (instr_vld_i)
      begin
         instr_q <= instr_i;
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n_i)
      begin
         vld_q <= 1'b0;
      end
      else
      begin
         vld_q <= instr_vld_i;
      end
   end

   // sort by major opcode, then funct3 for OP-V
   always_comb
   begin
      cls = vec_front_pkg::CLS_ILLEGAL;
      if (!vld_q)
      begin
         cls = vec_front_pkg::CLS_NONE;
      end
      else
      begin
         case (instr_q[6:0])
            vec_front_pkg::OPC_OP_V:
            begin
               case (instr_q[vec_front_pkg::FIELD_F3_LSB +: 3])
                  vec_front_pkg::F3_OPIVV,
                  vec_front_pkg::F3_OPMVV: cls = vec_front_pkg::CLS_ARITH_VV;
                  vec_front_pkg::F3_OPIVX: cls = vec_front_pkg::CLS_ARITH_VX;
                  vec_front_pkg::F3_OPIVI: cls = vec_front_pkg::CLS_ARITH_VI;
                  vec_front_pkg::F3_OPCFG: cls = vec_front_pkg::CLS_CFG;
                  // float and scalar-result forms are not handled here
                  default:                 cls = vec_front_pkg::CLS_ILLEGAL;
               endcase
            end
            vec_front_pkg::OPC_LOAD_FP:  cls = vec_front_pkg::CLS_LOAD;
            vec_front_pkg::OPC_STORE_FP: cls = vec_front_pkg::CLS_STORE;
            default:                     cls = vec_front_pkg::CLS_ILLEGAL;
         endcase
      end
   end

   assign vlmul = instr_q[vec_front_pkg::FIELD_VLMUL_LSB +: 3];

   assign dec.vld = vld_q;
   assign dec.cls = cls;
   assign dec.vd  = instr_q[vec_front_pkg::FIELD_VD_LSB +: 5];
   assign dec.vs1 = instr_q[vec_front_pkg::FIELD_VS1_LSB +: 5];
   assign dec.vs2 = instr_q[vec_front_pkg::FIELD_VS2_LSB +: 5];

   // fractional codes 4..7 fold onto a single register
   assign dec.lmul_field = vlmul[2] ? vec_front_pkg::LMUL_1
                                    : vec_front_pkg::lmul_e'(vlmul[1:0]);

endmodule

`default_nettype wire

// File: logic/renaming_unit.sv
`timescale 1ns/1ns
`default_nettype none

module renaming_unit
  #(
    parameter int VLEN      = 4096,
    parameter int VLANE_NUM = 8
    )
   (
    dec_if.dst                       dec,
    input wire vec_front_pkg::lmul_e lmul_i,
    grp_if.src                       grp
    );

   localparam int MEM_DEPTH = VLEN / VLANE_NUM;
   localparam int AW        = $clog2(MEM_DEPTH);
   // words per lane taken by one architectural register
   localparam int REG_SIZE  = VLEN / vec_front_pkg::VREG_NUM / VLANE_NUM;

   typedef logic [vec_front_pkg::VREG_NUM-1:0][AW-1:0] base_tbl_t;

   // identity map for now, register r starts at r * REG_SIZE
   function automatic base_tbl_t init_base_tbl();
      base_tbl_t tbl;
      for (int r = 0; r < vec_front_pkg::VREG_NUM; r++)
      begin
         tbl[r] = AW'(r * REG_SIZE);
      end
      return tbl;
   endfunction

   localparam base_tbl_t BASE_TBL = init_base_tbl();

   // base of register reg_idx+k, wrapping past v31
   function automatic logic [AW-1:0] slot_base(input logic [4:0] reg_idx, input int k);
      logic [4:0] idx;
      idx = reg_idx + 5'(k);
      return BASE_TBL[idx];
   endfunction

   logic [4:0] rs1_idx;

   // store data register lives in the vd field
   assign rs1_idx = (dec.cls == vec_front_pkg::CLS_STORE) ? dec.vd : dec.vs1;

   always_comb
   begin
      for (int k = 0; k < vec_front_pkg::GROUP_MAX; k++)
      begin
         grp.waddr_grp[k]  = slot_base(dec.vd, k);
         grp.raddr0_grp[k] = slot_base(rs1_idx, k);
         grp.raddr1_grp[k] = slot_base(dec.vs2, k);
      end
   end

   // group size rides along with the addresses
   assign grp.lmul = lmul_i;

endmodule

`default_nettype wire

// File: logic/vcfg_regs.sv
`timescale 1ns/1ns
`default_nettype none

module vcfg_regs
  (
   input  wire logic            clk,
   input  wire logic            rst_n_i,
   dec_if.dst                   dec,
   output vec_front_pkg::lmul_e lmul_o
   );

   logic cfg_load;

   // vsetvli, vsetivli and vsetvl all land here
   assign cfg_load = dec.vld && (dec.cls == vec_front_pkg::CLS_CFG);

   // lmul_field already carries fractional codes as LMUL_1
   always_ff @(posedge clk)
   begin
      if (!rst_n_i)
      begin
         lmul_o <= vec_front_pkg::LMUL_1;
      end
      else if (cfg_load)
      begin
         lmul_o <= dec.lmul_field;
      end
   end

endmodule

`default_nettype wire

// File: logic/vec_front_ifs.sv
`timescale 1ns/1ns
`default_nettype none

// decoded instruction, fields qualified by vld
interface dec_if;
   logic                        vld;
   vec_front_pkg::instr_class_e cls;
   logic [4:0]                  vd;
   logic [4:0]                  vs1;
   logic [4:0]                  vs2;
   vec_front_pkg::lmul_e        lmul_field;

   modport src (output vld, cls, vd, vs1, vs2, lmul_field);
   modport dst (input vld, cls, vd, vs1, vs2, lmul_field);
endinterface

// starting addresses for a whole register group
interface grp_if
  #(
    parameter int AW = 9
    );
   logic [vec_front_pkg::GROUP_MAX-1:0][AW-1:0] waddr_grp;
   logic [vec_front_pkg::GROUP_MAX-1:0][AW-1:0] raddr0_grp;
   logic [vec_front_pkg::GROUP_MAX-1:0][AW-1:0] raddr1_grp;
   vec_front_pkg::lmul_e                        lmul;

   modport src (output waddr_grp, raddr0_grp, raddr1_grp, lmul);
   modport dst (input waddr_grp, raddr0_grp, raddr1_grp, lmul);
endinterface

`default_nettype wire

// File: logic/vec_front_pkg.sv
`default_nettype none

package vec_front_pkg;

   // architectural register file
   localparam int VREG_NUM  = 32;
   localparam int GROUP_MAX = 8;

   // major opcodes of the vector extension
   typedef enum logic [6:0] {
      OPC_LOAD_FP  = 7'h07,
      OPC_STORE_FP = 7'h27,
      OPC_OP_V     = 7'h57
   } opcode_e;

   // funct3 of OP-V
   typedef enum logic [2:0] {
      F3_OPIVV = 3'd0,
      F3_OPFVV = 3'd1,
      F3_OPMVV = 3'd2,
      F3_OPIVI = 3'd3,
      F3_OPIVX = 3'd4,
      F3_OPFVF = 3'd5,
      F3_OPMVX = 3'd6,
      F3_OPCFG = 3'd7
   } vfunct3_e;

   // instruction field positions
   localparam int FIELD_VD_LSB    = 7;
   localparam int FIELD_F3_LSB    = 12;
   localparam int FIELD_VS1_LSB   = 15;
   localparam int FIELD_VS2_LSB   = 20;
   localparam int FIELD_VLMUL_LSB = 20;

   typedef enum logic [2:0] {
      CLS_NONE     = 3'd0,
      CLS_ARITH_VV = 3'd1,
      CLS_ARITH_VX = 3'd2,
      CLS_ARITH_VI = 3'd3,
      CLS_LOAD     = 3'd4,
      CLS_STORE    = 3'd5,
      CLS_CFG      = 3'd6,
      CLS_ILLEGAL  = 3'd7
   } instr_class_e;

   // same encoding as vlmul codes 0 to 3
   typedef enum logic [1:0] {
      LMUL_1 = 2'd0,
      LMUL_2 = 2'd1,
      LMUL_4 = 2'd2,
      LMUL_8 = 2'd3
   } lmul_e;

endpackage

`default_nettype wire

// File: logic/vec_front_top.sv
`timescale 1ns/1ns
`default_nettype none

module vec_front_top
  #(
    parameter int  VLEN      = 4096,
    parameter int  VLANE_NUM = 8,
    localparam int AW        = $clog2(VLEN / VLANE_NUM)
    )
   (
    input  wire logic                 clk,
    input  wire logic                 rst_n_i,
    input  wire logic                 instr_vld_i,
    input  wire logic [31:0]          instr_i,
    input  wire logic                 stall_i,
    output wire logic                 busy_o,
    output wire logic                 addr_vld_o,
    output wire logic [AW-1:0]        waddr_o,
    output wire logic [AW-1:0]        raddr0_o,
    output wire logic [AW-1:0]        raddr1_o,
    output wire logic                 beat_last_o,
    output wire logic                 illegal_o,
    output wire vec_front_pkg::lmul_e lmul_o
    );

   dec_if            u_dec_if ();
   grp_if #(.AW(AW)) u_grp_if ();

   instr_classifier u_classifier
     (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .instr_vld_i (instr_vld_i),
      .instr_i     (instr_i),
      .dec         (u_dec_if.src)
      );

   vcfg_regs u_vcfg
     (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .dec     (u_dec_if.dst),
      .lmul_o  (lmul_o)
      );

   // current group size feeds renaming alongside the decoded fields
   renaming_unit
     #(
       .VLEN      (VLEN),
       .VLANE_NUM (VLANE_NUM)
       )
   u_rename
     (
      .dec    (u_dec_if.dst),
      .lmul_i (lmul_o),
      .grp    (u_grp_if.src)
      );

   vrf_beat_seq
     #(
       .VLEN      (VLEN),
       .VLANE_NUM (VLANE_NUM)
       )
   u_seq
     (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .dec         (u_dec_if.dst),
      .grp         (u_grp_if.dst),
      .stall_i     (stall_i),
      .busy_o      (busy_o),
      .addr_vld_o  (addr_vld_o),
      .waddr_o     (waddr_o),
      .raddr0_o    (raddr0_o),
      .raddr1_o    (raddr1_o),
      .beat_last_o (beat_last_o),
      .illegal_o   (illegal_o)
      );

endmodule

`default_nettype wire

// File: logic/vrf_beat_seq.sv
`timescale 1ns/1ns
`default_nettype none

module vrf_beat_seq
  #(
    parameter int  VLEN      = 4096,
    parameter int  VLANE_NUM = 8,
    localparam int MEM_DEPTH = VLEN / VLANE_NUM,
    localparam int AW        = $clog2(MEM_DEPTH)
    )
   (
    input  wire logic  clk,
    input  wire logic  rst_n_i,
    dec_if.dst         dec,
    grp_if.dst         grp,
    input  wire logic  stall_i,
    output logic       busy_o,
    output logic       addr_vld_o,
    output logic [AW-1:0] waddr_o,
    output logic [AW-1:0] raddr0_o,
    output logic [AW-1:0] raddr1_o,
    output logic       beat_last_o,
    output logic       illegal_o
    );

   typedef enum logic {
      SEQ_IDLE,
      SEQ_RUN
   } seq_state_e;

   seq_state_e state_q;
   logic [2:0] beat_q;
   logic [2:0] last_idx_q;
   logic [vec_front_pkg::GROUP_MAX-1:0][AW-1:0] wgrp_q;
   logic [vec_front_pkg::GROUP_MAX-1:0][AW-1:0] r0grp_q;
   logic [vec_front_pkg::GROUP_MAX-1:0][AW-1:0] r1grp_q;
   logic       run_cls;
   logic       start;
   logic       accept;
   logic       last_beat;

   // index of the final beat for a group size
   function automatic logic [2:0] last_index(input vec_front_pkg::lmul_e lmul);
      logic [2:0] idx;
      case (lmul)
         vec_front_pkg::LMUL_2: idx = 3'd1;
         vec_front_pkg::LMUL_4: idx = 3'd3;
         vec_front_pkg::LMUL_8: idx = 3'd7;
         default:               idx = 3'd0;
      endcase
      return idx;
   endfunction

   // only classes that touch the register file get beats
   assign run_cls = dec.cls inside {vec_front_pkg::CLS_ARITH_VV, vec_front_pkg::CLS_ARITH_VX,
                                    vec_front_pkg::CLS_ARITH_VI, vec_front_pkg::CLS_LOAD,
                                    vec_front_pkg::CLS_STORE};

   assign start     = dec.vld && run_cls && (state_q == SEQ_IDLE);
   assign accept    = addr_vld_o && !stall_i;
   assign last_beat = (beat_q == last_idx_q);

   always_ff @(posedge clk)
   begin
      if (!rst_n_i)
      begin
         state_q    <= SEQ_IDLE;
         beat_q     <= 3'd0;
         last_idx_q <= 3'd0;
      end
      else
      begin
         case (state_q)
            SEQ_IDLE:
            begin
               if (start)
               begin
                  state_q    <= SEQ_RUN;
                  beat_q     <= 3'd0;
                  last_idx_q <= last_index(grp.lmul);
               end
            end
            SEQ_RUN:
            begin
               if (accept)
               begin
                  if (last_beat)
                  begin
                     state_q <= SEQ_IDLE;
                  end
                  beat_q <= beat_q + 3'd1;
               end
            end
            default: state_q <= SEQ_IDLE;
         endcase
      end
   end

   // group snapshot, renaming output is only valid with dec.vld
   always_ff @(posedge clk)
   begin
      if (start)
      begin
         wgrp_q  <= grp.waddr_grp;
         r0grp_q <= grp.raddr0_grp;
         r1grp_q <= grp.raddr1_grp;
      end
   end

   assign addr_vld_o  = (state_q == SEQ_RUN);
   assign beat_last_o = addr_vld_o && last_beat;
   assign waddr_o     = wgrp_q[beat_q];
   assign raddr0_o    = r0grp_q[beat_q];
   assign raddr1_o    = r1grp_q[beat_q];

   // decode cycle counts as busy even when no beats follow
   assign busy_o    = dec.vld || addr_vld_o;
   assign illegal_o = dec.vld && (dec.cls == vec_front_pkg::CLS_ILLEGAL);

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ns --top-module tb_vec_front \
   -f build.f --Mdir obj_dir -o tb_vec_front_sim || { echo "build failed"; exit 1; }
sim_out="$(./obj_dir/tb_vec_front_sim)"
echo "$sim_out"
grep -qx "Regression passed" <<< "$sim_out" && echo "simulation ok" \
   || { echo "simulation reported failure"; exit 1; }

// File: verif/tb_vec_front.sv
`timescale 1ns/1ns
`default_nettype none

module tb_vec_front;

   localparam int VLEN          = 4096;
   localparam int VLANE_NUM     = 8;
   localparam int AW            = $clog2(VLEN / VLANE_NUM);
   // words per lane for one architectural register
   localparam int REG_WORDS     = VLEN / 32 / VLANE_NUM;
   localparam int CLK_PERIOD    = 40;
   localparam int RESET_CYCLES  = 16;
   localparam int MAX_STALL_RUN = 3;
   // instruction count over all tests and worst case cycles per beat
   localparam int N_INSTR       = 28;
   localparam int STALL_FACTOR  = MAX_STALL_RUN + 1;
   localparam int MARGIN_CYCLES = 4 * N_INSTR + RESET_CYCLES + 100;
   localparam int WATCHDOG_NS   = (N_INSTR * 8 * STALL_FACTOR + MARGIN_CYCLES) * CLK_PERIOD;
   localparam int IDLE_WAIT_MAX = 8 * STALL_FACTOR + 4;

   logic                 clk;
   logic                 rst_n_i;
   logic                 instr_vld_i;
   logic [31:0]          instr_i;
   logic                 stall_i;
   logic                 busy_o;
   logic                 addr_vld_o;
   logic [AW-1:0]        waddr_o;
   logic [AW-1:0]        raddr0_o;
   logic [AW-1:0]        raddr1_o;
   logic                 beat_last_o;
   logic                 illegal_o;
   vec_front_pkg::lmul_e lmul_o;

   int                   mismatch_cnt = 0;
   int                   other_cnt    = 0;
   int                   stall_run    = 0;
   integer               seed         = 32'h76fa4640;
   // group size the model expects after the last vsetvli
   vec_front_pkg::lmul_e model_lmul   = vec_front_pkg::LMUL_1;

   vec_front_top u_dut
     (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .instr_vld_i (instr_vld_i),
      .instr_i     (instr_i),
      .stall_i     (stall_i),
      .busy_o      (busy_o),
      .addr_vld_o  (addr_vld_o),
      .waddr_o     (waddr_o),
      .raddr0_o    (raddr0_o),
      .raddr1_o    (raddr1_o),
      .beat_last_o (beat_last_o),
      .illegal_o   (illegal_o),
      .lmul_o      (lmul_o)
      );

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // model base of register r at r * REG_WORDS with the index wrapping at 32
   function automatic logic [AW-1:0] base_addr(input int r);
      return AW'((r % 32) * REG_WORDS);
   endfunction

   function automatic int beats_for(input vec_front_pkg::lmul_e lmul);
      case (lmul)
         vec_front_pkg::LMUL_2: return 2;
         vec_front_pkg::LMUL_4: return 4;
         vec_front_pkg::LMUL_8: return 8;
         default:               return 1;
      endcase
   endfunction

   // fractional codes 4 to 7 give a single register
   function automatic vec_front_pkg::lmul_e lmul_from_vlmul(input logic [2:0] vlmul);
      case (vlmul)
         3'd1:    return vec_front_pkg::LMUL_2;
         3'd2:    return vec_front_pkg::LMUL_4;
         3'd3:    return vec_front_pkg::LMUL_8;
         default: return vec_front_pkg::LMUL_1;
      endcase
   endfunction

   function automatic logic [31:0] enc_opv(input logic [2:0] f3, input logic [4:0] vd,
                                           input logic [4:0] vs1, input logic [4:0] vs2);
      return {6'b000000, 1'b1, vs2, vs1, f3, vd, vec_front_pkg::OPC_OP_V};
   endfunction

   // indexed load or store with vs3 in the vd field
   function automatic logic [31:0] enc_mem(input logic [6:0] opc, input logic [4:0] vd,
                                           input logic [4:0] rs1, input logic [4:0] vs2);
      return {3'b000, 1'b0, 2'b11, 1'b1, vs2, rs1, 3'b111, vd, opc};
   endfunction

   function automatic logic [31:0] enc_vsetvli(input logic [2:0] vlmul);
      return {1'b0, 8'h00, vlmul, 5'd0, 3'b111, 5'd0, vec_front_pkg::OPC_OP_V};
   endfunction

   function automatic logic [4:0] random_reg();
      return 5'($random(seed));
   endfunction

   // stall runs are capped so each beat takes at most STALL_FACTOR cycles
   function automatic bit pick_stall(input int pct);
      int roll;
      if (pct == 0 || stall_run >= MAX_STALL_RUN)
      begin
         stall_run = 0;
         return 1'b0;
      end
      roll = $unsigned($random(seed)) % 100;
      if (roll < pct)
      begin
         stall_run++;
         return 1'b1;
      end
      stall_run = 0;
      return 1'b0;
   endfunction

   task automatic check_addr(input string name, input logic [AW-1:0] got,
                             input logic [AW-1:0] exp);
      if (got !== exp)
      begin
         mismatch_cnt++;
         $display("mismatch %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic check_lmul(input string name, input vec_front_pkg::lmul_e got,
                             input vec_front_pkg::lmul_e exp);
      if (got !== exp)
      begin
         mismatch_cnt++;
         $display("mismatch %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp)
      begin
         mismatch_cnt++;
         $display("mismatch %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic report_failure(input string what);
      other_cnt++;
      $display("error: %s at %0t", what, $time);
   endtask

   task automatic apply_reset();
      repeat (RESET_CYCLES) @(posedge clk);
      rst_n_i <= 1'b1;
      @(negedge clk);
      check_bit("busy_o", busy_o, 1'b0);
      check_bit("addr_vld_o", addr_vld_o, 1'b0);
      check_bit("beat_last_o", beat_last_o, 1'b0);
      check_bit("illegal_o", illegal_o, 1'b0);
      check_lmul("lmul_o", lmul_o, vec_front_pkg::LMUL_1);
   endtask

   task automatic wait_until_idle();
      int waited;
      waited = 0;
      @(negedge clk);
      while (busy_o && waited < IDLE_WAIT_MAX)
      begin
         @(negedge clk);
         waited++;
      end
      if (busy_o)
      begin
         report_failure("busy_o stayed high, next instruction issued anyway");
      end
   endtask

   // strobe one word and follow its beats until busy_o drops
   task automatic issue_and_collect(input logic [31:0] word, input int n_beats,
                                    input logic [4:0] w_reg, input logic [4:0] r0_reg,
                                    input logic [4:0] r1_reg, input logic exp_illegal,
                                    input int stall_pct);
      int            beat;
      bit            stalled;
      bit            held;
      logic [AW-1:0] prev_w;
      logic [AW-1:0] prev_r0;
      logic [AW-1:0] prev_r1;
      beat = 0;
      held = 1'b0;
      wait_until_idle();
      @(posedge clk);
      instr_vld_i <= 1'b1;
      instr_i     <= word;
      @(posedge clk);
      instr_vld_i <= 1'b0;
      // decode cycle has no beat yet
      @(negedge clk);
      check_bit("busy_o", busy_o, 1'b1);
      check_bit("addr_vld_o", addr_vld_o, 1'b0);
      check_bit("illegal_o", illegal_o, exp_illegal);
      while (beat < n_beats)
      begin
         @(posedge clk);
         stalled = pick_stall(stall_pct);
         stall_i <= stalled;
         @(negedge clk);
         if (addr_vld_o !== 1'b1)
         begin
            report_failure($sformatf("addr_vld_o low before beat %0d of %0d", beat, n_beats));
            break;
         end
         if (held)
         begin
            check_addr("waddr_o while stalled", waddr_o, prev_w);
            check_addr("raddr0_o while stalled", raddr0_o, prev_r0);
            check_addr("raddr1_o while stalled", raddr1_o, prev_r1);
         end
         check_addr("waddr_o", waddr_o, base_addr(int'(w_reg) + beat));
         check_addr("raddr0_o", raddr0_o, base_addr(int'(r0_reg) + beat));
         check_addr("raddr1_o", raddr1_o, base_addr(int'(r1_reg) + beat));
         check_bit("beat_last_o", beat_last_o, beat == n_beats - 1);
         check_bit("busy_o", busy_o, 1'b1);
         check_bit("illegal_o", illegal_o, 1'b0);
         prev_w  = waddr_o;
         prev_r0 = raddr0_o;
         prev_r1 = raddr1_o;
         held    = stalled;
         if (!stalled)
         begin
            beat++;
         end
      end
      @(posedge clk);
      stall_i <= 1'b0;
      @(negedge clk);
      check_bit("busy_o after group", busy_o, 1'b0);
      check_bit("addr_vld_o after group", addr_vld_o, 1'b0);
      check_bit("illegal_o after decode", illegal_o, 1'b0);
   endtask

   task automatic apply_vsetvli(input logic [2:0] vlmul);
      issue_and_collect(enc_vsetvli(vlmul), 0, 5'd0, 5'd0, 5'd0, 1'b0, 0);
      model_lmul = lmul_from_vlmul(vlmul);
      check_lmul("lmul_o", lmul_o, model_lmul);
   endtask

   task automatic issue_random_vv(input int stall_pct);
      logic [4:0] vd;
      logic [4:0] vs1;
      logic [4:0] vs2;
      vd  = random_reg();
      vs1 = random_reg();
      vs2 = random_reg();
      issue_and_collect(enc_opv(vec_front_pkg::F3_OPIVV, vd, vs1, vs2), beats_for(model_lmul),
                        vd, vs1, vs2, 1'b0, stall_pct);
   endtask

   task automatic single_beat_after_reset();
      issue_random_vv(0);
      check_lmul("lmul_o", lmul_o, vec_front_pkg::LMUL_1);
   endtask

   task automatic lmul_sweep();
      for (int code = 0; code < 4; code++)
      begin
         apply_vsetvli(3'(code));
         issue_random_vv(0);
      end
      // LMUL 4 group from v30 wraps to v0 and v1
      apply_vsetvli(3'd2);
      issue_and_collect(enc_opv(vec_front_pkg::F3_OPIVV, 5'd30, 5'd29, 5'd31),
                        beats_for(model_lmul), 5'd30, 5'd29, 5'd31, 1'b0, 0);
      apply_vsetvli(3'd6);
      issue_random_vv(0);
   endtask

   task automatic memory_and_scalar_forms();
      logic [4:0] a;
      logic [4:0] b;
      logic [4:0] c;
      apply_vsetvli(3'd1);
      a = random_reg();
      b = random_reg();
      c = random_reg();
      // store data register read through raddr0
      issue_and_collect(enc_mem(vec_front_pkg::OPC_STORE_FP, a, b, c), beats_for(model_lmul),
                        a, a, c, 1'b0, 0);
      issue_and_collect(enc_mem(vec_front_pkg::OPC_LOAD_FP, b, c, a), beats_for(model_lmul),
                        b, c, a, 1'b0, 0);
      issue_and_collect(enc_opv(vec_front_pkg::F3_OPIVI, c, a, b), beats_for(model_lmul),
                        c, a, b, 1'b0, 0);
      issue_and_collect(enc_opv(vec_front_pkg::F3_OPIVX, a, c, b), beats_for(model_lmul),
                        a, c, b, 1'b0, 0);
      issue_and_collect(enc_opv(vec_front_pkg::F3_OPMVV, b, a, c), beats_for(model_lmul),
                        b, a, c, 1'b0, 0);
   endtask

   task automatic stalled_lmul8_groups();
      apply_vsetvli(3'd3);
      repeat (4)
      begin
         issue_random_vv(40);
      end
   endtask

   task automatic illegal_opcode_recovery();
      apply_vsetvli(3'd1);
      issue_and_collect({7'h00, 5'd3, 5'd2, 3'b000, 5'd1, 7'h33}, 0, 5'd0, 5'd0, 5'd0, 1'b1, 0);
      check_lmul("lmul_o after illegal opcode", lmul_o, model_lmul);
      // float funct3 under OP-V is rejected as well
      issue_and_collect(enc_opv(vec_front_pkg::F3_OPFVV, 5'd4, 5'd5, 5'd6), 0,
                        5'd0, 5'd0, 5'd0, 1'b1, 0);
      check_lmul("lmul_o after illegal funct3", lmul_o, model_lmul);
      issue_random_vv(25);
   endtask

   initial
   begin
      #(WATCHDOG_NS);
      other_cnt++;
      $display("error: watchdog expired after %0d ns, tests did not complete", WATCHDOG_NS);
      $display("checks done: %0d mismatches, %0d other errors", mismatch_cnt, other_cnt);
      $display("Regression failed");
      $finish;
   end

   initial
   begin
      rst_n_i     = 1'b0;
      instr_vld_i = 1'b0;
      instr_i     = 32'h0;
      stall_i     = 1'b0;
      apply_reset();
      single_beat_after_reset();
      lmul_sweep();
      memory_and_scalar_forms();
      stalled_lmul8_groups();
      illegal_opcode_recovery();
      $display("checks done: %0d mismatches, %0d other errors", mismatch_cnt, other_cnt);
      if (mismatch_cnt == 0 && other_cnt == 0)
      begin
         $display("Regression passed");
      end
      else
      begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

`default_nettype wire
